// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

////////////////////
// datapath sizing
////////////////////

`define DATA_W 32               // data and address width
`define REG_AW 5                // register index width

////////////////////
// fixed words
////////////////////

// boot ROM base in kseg1
`define RESET_PC 32'hbfc0_0000

`define NOP_WORD 32'h0000_0000  // sll $0, $0, 0

`endif

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        CTRL_NONE, CTRL_LOAD, CTRL_STORE, CTRL_BEQ, CTRL_BNE, CTRL_JUMP
    } ctrl_e;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fields_t;

    // low half is either R-type fields or the 16-bit immediate
    typedef union packed {
        r_fields_t   r;
        logic [15:0] imm16;
    } low_half_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        low_half_t  lo;
    } inst_t;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

`include "cpu_macros.svh"

package pipe_pkg;
    import isa_pkg::*;

    typedef struct packed {
        logic              valid;
        logic [`DATA_W-1:0] pc;
    } fd_t;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] pc;
        logic [25:0]        index;     // j target field
        alu_op_e            alu_op;
        ctrl_e              ctrl;
        logic               imm_sel;   // operand b from imm
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`DATA_W-1:0] rs_val;
        logic [`DATA_W-1:0] rt_val;
        logic [`DATA_W-1:0] imm;       // already extended
        logic [4:0]         shamt;
        logic [`REG_AW-1:0] dest;
        logic               we;
    } de_t;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] result;    // alu value or effective address
        logic [`DATA_W-1:0] store_data;
        ctrl_e              ctrl;
        logic [`REG_AW-1:0] dest;
        logic               we;
        logic [`DATA_W-1:0] pc;
    } em_t;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] result;
        logic               is_load;   // take sram read data instead
        logic [`REG_AW-1:0] dest;
        logic               we;
        logic [`DATA_W-1:0] pc;
    } mw_t;

endpackage

`default_nettype wire

// ==== pipe_reg.sv ====
`default_nettype none
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,      // keep contents
    input  logic     squash,    // load an empty slot
    input  payload_t d,
    output payload_t q
);

    // an all-zero payload has valid clear
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;
        end else if (squash) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module fetch_stage import pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               redirect,
    input  logic [`DATA_W-1:0] redirect_pc,
    output logic [`DATA_W-1:0] inst_sram_addr,
    output fd_t                fd
);

    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] pc_next;

    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;      // taken branch or j
        end else if (stall) begin
            pc_next = pc;               // load-use
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign inst_sram_addr = pc;         // sram samples it at the edge

    // the fd register stays cleared until reset is released
    assign fd.valid = 1'b1;
    assign fd.pc    = pc;

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  fd_t                fd,
    input  logic [`DATA_W-1:0] inst_word,
    input  logic [`REG_AW-1:0] ex_load_dest,
    input  logic               ex_is_load,
    input  mw_t                wb,
    input  logic [`DATA_W-1:0] load_data,
    output de_t                de,
    output logic               stall,
    output logic [`DATA_W-1:0] debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output logic [`REG_AW-1:0] debug_wb_rf_wnum,
    output logic [`DATA_W-1:0] debug_wb_rf_wdata
);

    localparam int NUM_REGS = 1 << `REG_AW;

    logic [`DATA_W-1:0] regs [NUM_REGS];
    logic [`DATA_W-1:0] held_word;
    logic               use_held;
    logic [`DATA_W-1:0] cur_word;
    inst_t              inst;
    logic               rf_we;
    logic [`DATA_W-1:0] rf_wdata;
    alu_op_e            alu_op;
    ctrl_e              ctrl;
    logic               imm_sel;
    logic               zero_ext;
    logic [`REG_AW-1:0] dest;
    logic               wr;
    logic               uses_rs;
    logic               uses_rt;

    ////////////////////
    // instruction word
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            use_held <= 1'b0;
        end else begin
            use_held <= stall;      // sram has moved on by then
        end
    end

    always_ff @(posedge clk) begin
        held_word <= cur_word;
    end

    assign cur_word = use_held ? held_word : inst_word;
    assign inst     = fd.valid ? inst_t'(cur_word) : inst_t'(`NOP_WORD);

    ////////////////////
    // decoder
    ////////////////////

    always_comb begin
        alu_op   = ALU_ADD;
        ctrl     = CTRL_NONE;
        imm_sel  = 1'b0;
        zero_ext = 1'b0;
        dest     = inst.rt;
        wr       = 1'b0;
        uses_rs  = 1'b0;
        uses_rt  = 1'b0;
        case (inst.opcode)
            OP_SPECIAL: begin
                dest    = inst.lo.r.rd;
                wr      = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                case (inst.lo.r.funct)
                    F_ADDU:  alu_op = ALU_ADD;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_XOR:   alu_op = ALU_XOR;
                    F_NOR:   alu_op = ALU_NOR;
                    F_SLT:   alu_op = ALU_SLT;
                    F_SLTU:  alu_op = ALU_SLTU;
                    F_SLL:   alu_op = ALU_SLL;
                    F_SRL:   alu_op = ALU_SRL;
                    F_SRA:   alu_op = ALU_SRA;
                    default: wr = 1'b0;         // unknown funct is a no-op
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                wr      = 1'b1;
                imm_sel = 1'b1;
                uses_rs = 1'b1;
                case (inst.opcode)
                    OP_SLTI:  alu_op = ALU_SLT;
                    OP_SLTIU: alu_op = ALU_SLTU;    // compare against sign-extended imm
                    OP_ANDI:  alu_op = ALU_AND;
                    OP_ORI:   alu_op = ALU_OR;
                    OP_XORI:  alu_op = ALU_XOR;
                    OP_LUI:   alu_op = ALU_LUI;
                    default:  alu_op = ALU_ADD;
                endcase
                zero_ext = inst.opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
            end
            OP_LW: begin
                ctrl    = CTRL_LOAD;
                wr      = 1'b1;
                imm_sel = 1'b1;
                uses_rs = 1'b1;
            end
            OP_SW: begin
                ctrl    = CTRL_STORE;
                imm_sel = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl    = (inst.opcode == OP_BEQ) ? CTRL_BEQ : CTRL_BNE;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            OP_J:    ctrl = CTRL_JUMP;
            default: ctrl = CTRL_NONE;
        endcase
    end

    // load in execute feeding this instruction
    assign stall = fd.valid && ex_is_load && (ex_load_dest != '0)
                   && ((uses_rs && inst.rs == ex_load_dest)
                   ||  (uses_rt && inst.rt == ex_load_dest));

    ////////////////////
    // register file
    ////////////////////

    assign rf_we    = wb.valid && wb.we && (wb.dest != '0);
    assign rf_wdata = wb.is_load ? load_data : wb.result;

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[wb.dest] <= rf_wdata;
        end
    end

    function automatic logic [`DATA_W-1:0] rf_read(input logic [`REG_AW-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (rf_we && idx == wb.dest) begin
            return rf_wdata;        // write-through
        end
        return regs[idx];
    endfunction

    always_comb begin
        de.valid   = fd.valid;
        de.pc      = fd.pc;
        de.index   = {inst.rs, inst.rt, inst.lo.imm16};
        de.alu_op  = alu_op;
        de.ctrl    = ctrl;
        de.imm_sel = imm_sel;
        de.rs      = inst.rs;
        de.rt      = inst.rt;
        de.rs_val  = rf_read(inst.rs);
        de.rt_val  = rf_read(inst.rt);
        de.imm     = zero_ext ? {16'h0, inst.lo.imm16}
                              : {{16{inst.lo.imm16[15]}}, inst.lo.imm16};
        de.shamt   = inst.lo.r.shamt;
        de.dest    = dest;
        de.we      = wr;
    end

    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb.dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  de_t                de,
    input  em_t                mem_fwd,
    input  logic [`REG_AW-1:0] wb_dest,
    input  logic               wb_we,
    input  logic [`DATA_W-1:0] wb_data,
    output em_t                em,
    output logic               redirect,
    output logic [`DATA_W-1:0] redirect_pc
);

    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] rt_fwd;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] alu_y;
    logic [`DATA_W-1:0] slot_pc;
    logic               equal;
    logic               taken;

    ////////////////////
    // forwarding
    ////////////////////

    always_comb begin
        if (de.rs == '0) begin
            op_a = '0;
        end else if (mem_fwd.valid && mem_fwd.we && mem_fwd.dest == de.rs) begin
            op_a = mem_fwd.result;
        end else if (wb_we && wb_dest == de.rs) begin
            op_a = wb_data;
        end else begin
            op_a = de.rs_val;
        end
    end

    always_comb begin
        if (de.rt == '0) begin
            rt_fwd = '0;
        end else if (mem_fwd.valid && mem_fwd.we && mem_fwd.dest == de.rt) begin
            rt_fwd = mem_fwd.result;
        end else if (wb_we && wb_dest == de.rt) begin
            rt_fwd = wb_data;
        end else begin
            rt_fwd = de.rt_val;
        end
    end

    assign op_b = de.imm_sel ? de.imm : rt_fwd;

    ////////////////////
    // alu
    ////////////////////

    always_comb begin
        case (de.alu_op)
            ALU_SUB:  alu_y = op_a - op_b;
            ALU_AND:  alu_y = op_a & op_b;
            ALU_OR:   alu_y = op_a | op_b;
            ALU_XOR:  alu_y = op_a ^ op_b;
            ALU_NOR:  alu_y = ~(op_a | op_b);
            ALU_SLT:  alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_y = {31'd0, op_a < op_b};
            ALU_SLL:  alu_y = op_b << de.shamt;
            ALU_SRL:  alu_y = op_b >> de.shamt;
            ALU_SRA:  alu_y = $signed(op_b) >>> de.shamt;
            ALU_LUI:  alu_y = {op_b[15:0], 16'h0};
            default:  alu_y = op_a + op_b;      // also lw/sw address
        endcase
    end

    ////////////////////
    // branch and jump
    ////////////////////

    assign slot_pc = de.pc + 32'd4;
    assign equal   = (op_a == rt_fwd);

    always_comb begin
        case (de.ctrl)
            CTRL_BEQ:  taken = equal;
            CTRL_BNE:  taken = !equal;
            CTRL_JUMP: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign redirect    = de.valid && taken;
    assign redirect_pc = (de.ctrl == CTRL_JUMP) ? {slot_pc[31:28], de.index, 2'b00}
                                                : slot_pc + {de.imm[29:0], 2'b00};

    assign em.valid      = de.valid;
    assign em.result     = alu_y;
    assign em.store_data = rt_fwd;
    assign em.ctrl       = de.ctrl;
    assign em.dest       = de.dest;
    assign em.we         = de.we;
    assign em.pc         = de.pc;

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module memory_stage import isa_pkg::*, pipe_pkg::*; (
    input  em_t                em,
    output logic [`DATA_W-1:0] data_sram_addr,
    output logic [3:0]         data_sram_wen,
    output logic [`DATA_W-1:0] data_sram_wdata,
    output mw_t                mw
);

    // word access only, so sw writes every byte lane
    assign data_sram_addr  = em.result;
    assign data_sram_wen   = (em.valid && em.ctrl == CTRL_STORE) ? 4'b1111 : 4'b0000;
    assign data_sram_wdata = em.store_data;

    assign mw.valid   = em.valid;
    assign mw.result  = em.result;
    assign mw.is_load = (em.ctrl == CTRL_LOAD);    // read data lands in writeback
    assign mw.dest    = em.dest;
    assign mw.we      = em.we;
    assign mw.pc      = em.pc;

endmodule

`default_nettype wire

// ==== mips_pipe_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module mips_pipe_top import isa_pkg::*, pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic               inst_sram_en,
    output logic [3:0]         inst_sram_wen,
    output logic [`DATA_W-1:0] inst_sram_addr,
    output logic [`DATA_W-1:0] inst_sram_wdata,
    input  logic [`DATA_W-1:0] inst_sram_rdata,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_wen,
    output logic [`DATA_W-1:0] data_sram_addr,
    output logic [`DATA_W-1:0] data_sram_wdata,
    input  logic [`DATA_W-1:0] data_sram_rdata,
    output logic [`DATA_W-1:0] debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output logic [`REG_AW-1:0] debug_wb_rf_wnum,
    output logic [`DATA_W-1:0] debug_wb_rf_wdata
);

    fd_t                fd_d, fd_q;
    de_t                de_d, de_q;
    em_t                em_d, em_q;
    mw_t                mw_d, mw_q;
    logic               stall;
    logic               redirect;
    logic [`DATA_W-1:0] redirect_pc;
    logic               ex_is_load;

    assign inst_sram_en    = 1'b1;     // read-only port
    assign inst_sram_wen   = 4'b0000;
    assign inst_sram_wdata = '0;
    assign data_sram_en    = 1'b1;

    assign ex_is_load = de_q.valid && (de_q.ctrl == CTRL_LOAD);

    fetch_stage fetch_stage_inst (
        .clk, .rst, .stall, .redirect, .redirect_pc,
        .inst_sram_addr, .fd(fd_d)
    );

    pipe_reg #(.payload_t(fd_t)) fd_reg (
        .clk, .rst, .hold(stall), .squash(redirect), .d(fd_d), .q(fd_q)
    );

    decode_stage decode_stage_inst (
        .clk, .rst, .fd(fd_q), .inst_word(inst_sram_rdata),
        .ex_load_dest(de_q.dest), .ex_is_load,
        .wb(mw_q), .load_data(data_sram_rdata), .de(de_d), .stall,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    // stall turns the decode slot into a bubble
    pipe_reg #(.payload_t(de_t)) de_reg (
        .clk, .rst, .hold(1'b0), .squash(stall), .d(de_d), .q(de_q)
    );

    execute_stage execute_stage_inst (
        .de(de_q), .mem_fwd(em_q),
        .wb_dest(debug_wb_rf_wnum), .wb_we(debug_wb_rf_wen[0]),
        .wb_data(debug_wb_rf_wdata),
        .em(em_d), .redirect, .redirect_pc
    );

    pipe_reg #(.payload_t(em_t)) em_reg (
        .clk, .rst, .hold(1'b0), .squash(1'b0), .d(em_d), .q(em_q)
    );

    memory_stage memory_stage_inst (
        .em(em_q), .data_sram_addr, .data_sram_wen, .data_sram_wdata, .mw(mw_d)
    );

    pipe_reg #(.payload_t(mw_t)) mw_reg (
        .clk, .rst, .hold(1'b0), .squash(1'b0), .d(mw_d), .q(mw_q)
    );

endmodule

`default_nettype wire

// ==== tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

////////////////////
// test program
////////////////////

localparam int PROG_LEN = 40;

// word n sits at RESET_PC + 4*n
localparam logic [31:0] prog_words [PROG_LEN] = '{
    32'h3c011234, 32'h34215678, 32'h2402ffff, 32'h00221821,  // lui ori addiu addu
    32'h00222023, 32'h00222824, 32'h00643025, 32'h00643826,  // subu and or xor
    32'h00014027, 32'h0041482a, 32'h0041502b, 32'h00015900,  // nor slt sltu sll
    32'h00086202, 32'h00086a03, 32'h304e8001, 32'h382fffff,  // srl sra andi xori
    32'h28500000, 32'h2c31ffff, 32'h24200005, 32'h00009021,  // slti sltiu, $0 writes
    32'h24130100, 32'hae610004, 32'h8e740004, 32'h0294a821,  // base, sw, lw, use
    32'h12810003, 32'h24160001, 32'h24160002, 32'h24160003,  // beq taken
    32'h14000004, 32'h24170007, 32'h24180008, 32'h16f80002,  // bne not taken, bne taken
    32'h24190009, 32'h2419000a, 32'h0bf00026, 32'h241a000b,  // j to +98
    32'h241a000c, 32'h241a000d, 32'h001ad821, 32'h00000000
};

////////////////////
// expected retirements
////////////////////

typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  wnum;
    logic [31:0] wdata;
} retire_t;

localparam int NUM_RETIRE = 28;

localparam retire_t exp_table [NUM_RETIRE] = '{
    '{32'hbfc00000, 5'd1,  32'h12340000}, '{32'hbfc00004, 5'd1,  32'h12345678},
    '{32'hbfc00008, 5'd2,  32'hffffffff}, '{32'hbfc0000c, 5'd3,  32'h12345677},
    '{32'hbfc00010, 5'd4,  32'h12345679}, '{32'hbfc00014, 5'd5,  32'h12345678},
    '{32'hbfc00018, 5'd6,  32'h1234567f}, '{32'hbfc0001c, 5'd7,  32'h0000000e},
    '{32'hbfc00020, 5'd8,  32'hedcba987}, '{32'hbfc00024, 5'd9,  32'h00000001},
    '{32'hbfc00028, 5'd10, 32'h00000000}, '{32'hbfc0002c, 5'd11, 32'h23456780},
    '{32'hbfc00030, 5'd12, 32'h00edcba9}, '{32'hbfc00034, 5'd13, 32'hffedcba9},
    '{32'hbfc00038, 5'd14, 32'h00008001}, '{32'hbfc0003c, 5'd15, 32'h1234a987},
    '{32'hbfc00040, 5'd16, 32'h00000001}, '{32'hbfc00044, 5'd17, 32'h00000001},
    '{32'hbfc0004c, 5'd18, 32'h00000000}, '{32'hbfc00050, 5'd19, 32'h00000100},
    '{32'hbfc00058, 5'd20, 32'h12345678}, '{32'hbfc0005c, 5'd21, 32'h2468acf0},
    '{32'hbfc00064, 5'd22, 32'h00000001}, '{32'hbfc00074, 5'd23, 32'h00000007},
    '{32'hbfc00078, 5'd24, 32'h00000008}, '{32'hbfc00080, 5'd25, 32'h00000009},
    '{32'hbfc0008c, 5'd26, 32'h0000000b}, '{32'hbfc00098, 5'd27, 32'h0000000b}
};

localparam logic [31:0] STORE_ADDR = 32'h0000_0104;  // sw $1, 4($19)
localparam logic [31:0] STORE_DATA = 32'h1234_5678;

`endif

// ==== tb_mips_pipe.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_mips_pipe;

    `include "tb_program.svh"

    localparam int CYCLE_LIMIT = 16 + 8 * NUM_RETIRE;

    logic        clk;
    logic        rst;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [31:0] inst_q;          // word read at the last rising edge
    logic [31:0] data_q;
    int          cycles;
    int          idx;
    logic        store_seen;

    mips_pipe_top mips_pipe_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    ////////////////////
    // sram models
    ////////////////////

    initial begin
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0000_0000;
            ram[i] = 32'hc0de_0000 ^ (i << 2);    // word tagged with its address
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rom[i] = prog_words[i];
        end
    end

    always @(posedge clk) begin
        inst_q <= rom[inst_sram_addr[9:2]];
        data_q <= ram[data_sram_addr[9:2]];      // old contents on a same-edge write
        if (data_sram_wen != 4'h0) begin
            ram[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata <= inst_q;
        data_sram_rdata <= data_q;
    end

    ////////////////////
    // timeout
    ////////////////////

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout after %0d cycles, %0d retirements seen", cycles, idx);
                $display("tests failed");
                $fatal(1);
            end
        end
    end

    ////////////////////
    // reset and retirement checker
    ////////////////////

    initial begin
        rst             = 1'b1;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        inst_q          = 32'h0;
        data_q          = 32'h0;
        idx             = 0;
        store_seen      = 1'b0;
        repeat (16) begin
            @(posedge clk);
            check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, 32'h0);
            check_value("data_sram_wen", {28'h0, data_sram_wen}, 32'h0);
        end
        @(negedge clk);
        rst = 1'b0;
        while (idx < NUM_RETIRE) begin
            @(posedge clk);
            // instruction port is read-only, both ports always enabled
            check_value("inst_sram_en", {31'h0, inst_sram_en}, 32'h1);
            check_value("inst_sram_wen", {28'h0, inst_sram_wen}, 32'h0);
            check_value("inst_sram_wdata", inst_sram_wdata, 32'h0);
            check_value("data_sram_en", {31'h0, data_sram_en}, 32'h1);
            if (data_sram_wen != 4'h0) begin
                check_value("data_sram_wen", {28'h0, data_sram_wen}, 32'hf);
                check_value("data_sram_addr", data_sram_addr, STORE_ADDR);
                check_value("data_sram_wdata", data_sram_wdata, STORE_DATA);
                store_seen = 1'b1;
            end
            if (debug_wb_rf_wen != 4'h0) begin
                check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, 32'hf);
                check_value("debug_wb_pc", debug_wb_pc, exp_table[idx].pc);
                check_value("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum},
                            {27'h0, exp_table[idx].wnum});
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_table[idx].wdata);
                idx++;
            end
        end
        if (store_seen) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("the store never reached the data SRAM");
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== mips_pipe.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
pipe_reg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_pipe_top.sv
tb_mips_pipe.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= tb_mips_pipe
FILELIST  ?= mips_pipe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
